// ==== common/ccm_pkg.sv ====
// ------------------------------
// shared widths and register map of the colour matrix
// coefficients are signed, 10 integer bits plus fraction
// the fraction width itself is a module parameter
// ------------------------------

package ccm_pkg;

    // ------------------------------
    // bus
    // ------------------------------
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // ------------------------------
    // coefficient format
    // ------------------------------
    localparam int COEFF_W = 18;

    // register addresses, one word each
    typedef enum logic [7:0] {
        MAT00     = 8'h00,
        MAT01     = 8'h01,
        MAT02     = 8'h02,
        MAT03     = 8'h03,
        MAT10     = 8'h04,
        MAT11     = 8'h05,
        MAT12     = 8'h06,
        MAT13     = 8'h07,
        MAT20     = 8'h08,
        MAT21     = 8'h09,
        MAT22     = 8'h0A,
        MAT23     = 8'h0B,
        // clip pairs per output channel
        CLIP_MIN0 = 8'h10,
        CLIP_MAX0 = 8'h11,
        CLIP_MIN1 = 8'h12,
        CLIP_MAX1 = 8'h13,
        CLIP_MIN2 = 8'h14,
        CLIP_MAX2 = 8'h15
    } reg_addr_e;

endpackage

// ==== ccm/ccm_regs.sv ====
// ------------------------------
// settings register bank, single cycle access
// ack follows the strobe combinationally, writes land on that edge
// assumes DATA_W of at most 32
// ------------------------------

`timescale 1ns/1ps

module ccm_regs import ccm_pkg::*; #(
    parameter int DATA_W       = 10,
    parameter int COEFF_FRAC_W = 8
) (
    input  logic                       clk,
    input  logic                       s_wb_rst_i,
    input  logic [WB_ADR_W-1:0]        s_wb_adr_i,
    input  logic [WB_DAT_W-1:0]        s_wb_dat_i,
    output logic [WB_DAT_W-1:0]        s_wb_dat_o,
    input  logic                       s_wb_we_i,
    input  logic [WB_SEL_W-1:0]        s_wb_sel_i,
    input  logic                       s_wb_stb_i,
    output logic                       s_wb_ack_o,
    output logic signed [COEFF_W-1:0]  mat00_o,
    output logic signed [COEFF_W-1:0]  mat01_o,
    output logic signed [COEFF_W-1:0]  mat02_o,
    output logic signed [COEFF_W-1:0]  mat03_o,
    output logic signed [COEFF_W-1:0]  mat10_o,
    output logic signed [COEFF_W-1:0]  mat11_o,
    output logic signed [COEFF_W-1:0]  mat12_o,
    output logic signed [COEFF_W-1:0]  mat13_o,
    output logic signed [COEFF_W-1:0]  mat20_o,
    output logic signed [COEFF_W-1:0]  mat21_o,
    output logic signed [COEFF_W-1:0]  mat22_o,
    output logic signed [COEFF_W-1:0]  mat23_o,
    output logic [DATA_W-1:0]          clip_min0_o,
    output logic [DATA_W-1:0]          clip_max0_o,
    output logic [DATA_W-1:0]          clip_min1_o,
    output logic [DATA_W-1:0]          clip_max1_o,
    output logic [DATA_W-1:0]          clip_min2_o,
    output logic [DATA_W-1:0]          clip_max2_o
);

    // gain of 1.0 in the coefficient format
    localparam logic signed [COEFF_W-1:0] UNITY = 1 << COEFF_FRAC_W;

    reg_addr_e adr;

    function automatic logic [WB_DAT_W-1:0] sext(input logic signed [COEFF_W-1:0] v);
        return {{(WB_DAT_W-COEFF_W){v[COEFF_W-1]}}, v};
    endfunction

    // replace only the selected byte lanes
    function automatic logic [WB_DAT_W-1:0] byte_merge(
        input logic [WB_DAT_W-1:0] old_v,
        input logic [WB_DAT_W-1:0] wdat,
        input logic [WB_SEL_W-1:0] sel
    );
        logic [WB_DAT_W-1:0] res;
        res = old_v;
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic signed [COEFF_W-1:0] merge_coeff(
        input logic signed [COEFF_W-1:0] old_v
    );
        logic [WB_DAT_W-1:0] m;
        m = byte_merge(sext(old_v), s_wb_dat_i, s_wb_sel_i);
        return m[COEFF_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] merge_clip(input logic [DATA_W-1:0] old_v);
        logic [WB_DAT_W-1:0] m;
        m = byte_merge(WB_DAT_W'(old_v), s_wb_dat_i, s_wb_sel_i);
        return m[DATA_W-1:0];
    endfunction

    assign adr        = reg_addr_e'(s_wb_adr_i);
    assign s_wb_ack_o = s_wb_stb_i;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            mat00_o     <= UNITY;
            mat01_o     <= '0;
            mat02_o     <= '0;
            mat03_o     <= '0;
            mat10_o     <= '0;
            mat11_o     <= UNITY;
            mat12_o     <= '0;
            mat13_o     <= '0;
            mat20_o     <= '0;
            mat21_o     <= '0;
            mat22_o     <= UNITY;
            mat23_o     <= '0;
            clip_min0_o <= '0;
            clip_max0_o <= '1;
            clip_min1_o <= '0;
            clip_max1_o <= '1;
            clip_min2_o <= '0;
            clip_max2_o <= '1;
        end else if (s_wb_stb_i && s_wb_we_i) begin
            case (adr)
                MAT00:     mat00_o     <= merge_coeff(mat00_o);
                MAT01:     mat01_o     <= merge_coeff(mat01_o);
                MAT02:     mat02_o     <= merge_coeff(mat02_o);
                MAT03:     mat03_o     <= merge_coeff(mat03_o);
                MAT10:     mat10_o     <= merge_coeff(mat10_o);
                MAT11:     mat11_o     <= merge_coeff(mat11_o);
                MAT12:     mat12_o     <= merge_coeff(mat12_o);
                MAT13:     mat13_o     <= merge_coeff(mat13_o);
                MAT20:     mat20_o     <= merge_coeff(mat20_o);
                MAT21:     mat21_o     <= merge_coeff(mat21_o);
                MAT22:     mat22_o     <= merge_coeff(mat22_o);
                MAT23:     mat23_o     <= merge_coeff(mat23_o);
                CLIP_MIN0: clip_min0_o <= merge_clip(clip_min0_o);
                CLIP_MAX0: clip_max0_o <= merge_clip(clip_max0_o);
                CLIP_MIN1: clip_min1_o <= merge_clip(clip_min1_o);
                CLIP_MAX1: clip_max1_o <= merge_clip(clip_max1_o);
                CLIP_MIN2: clip_min2_o <= merge_clip(clip_min2_o);
                CLIP_MAX2: clip_max2_o <= merge_clip(clip_max2_o);
                default: ;
            endcase
        end
    end

    // ------------------------------
    // readback
    // ------------------------------
    always_comb begin
        case (adr)
            MAT00:     s_wb_dat_o = sext(mat00_o);
            MAT01:     s_wb_dat_o = sext(mat01_o);
            MAT02:     s_wb_dat_o = sext(mat02_o);
            MAT03:     s_wb_dat_o = sext(mat03_o);
            MAT10:     s_wb_dat_o = sext(mat10_o);
            MAT11:     s_wb_dat_o = sext(mat11_o);
            MAT12:     s_wb_dat_o = sext(mat12_o);
            MAT13:     s_wb_dat_o = sext(mat13_o);
            MAT20:     s_wb_dat_o = sext(mat20_o);
            MAT21:     s_wb_dat_o = sext(mat21_o);
            MAT22:     s_wb_dat_o = sext(mat22_o);
            MAT23:     s_wb_dat_o = sext(mat23_o);
            CLIP_MIN0: s_wb_dat_o = WB_DAT_W'(clip_min0_o);
            CLIP_MAX0: s_wb_dat_o = WB_DAT_W'(clip_max0_o);
            CLIP_MIN1: s_wb_dat_o = WB_DAT_W'(clip_min1_o);
            CLIP_MAX1: s_wb_dat_o = WB_DAT_W'(clip_max1_o);
            CLIP_MIN2: s_wb_dat_o = WB_DAT_W'(clip_min2_o);
            CLIP_MAX2: s_wb_dat_o = WB_DAT_W'(clip_max2_o);
            default:   s_wb_dat_o = '0;
        endcase
    end

endmodule

// ==== ccm/ccm_channel.sv ====
// ------------------------------
// one output row of the matrix, latency 3
// gains and offset sampled at stage 1, clip limits at stage 3
// COEFF_FRAC_W must be at least 1
// ------------------------------

`timescale 1ns/1ps

module ccm_channel import ccm_pkg::*; #(
    parameter int DATA_W       = 10,
    parameter int COEFF_FRAC_W = 8
) (
    input  logic                      clk,
    input  logic [DATA_W-1:0]         color0_i,
    input  logic [DATA_W-1:0]         color1_i,
    input  logic [DATA_W-1:0]         color2_i,
    input  logic signed [COEFF_W-1:0] gain0_i,
    input  logic signed [COEFF_W-1:0] gain1_i,
    input  logic signed [COEFF_W-1:0] gain2_i,
    input  logic signed [COEFF_W-1:0] offset_i,
    input  logic [DATA_W-1:0]         clip_min_i,
    input  logic [DATA_W-1:0]         clip_max_i,
    output logic [DATA_W-1:0]         color_o
);

    // colour gets a zero sign bit before the multiply
    localparam int PROD_W = DATA_W + 1 + COEFF_W;
    // three products plus offset need two more bits
    localparam int SUM_W  = PROD_W + 2;

    localparam logic signed [SUM_W:0] HALF = 1 << (COEFF_FRAC_W - 1);

    logic signed [PROD_W-1:0]  prod0_q;
    logic signed [PROD_W-1:0]  prod1_q;
    logic signed [PROD_W-1:0]  prod2_q;
    logic signed [COEFF_W-1:0] offset_q;
    logic signed [SUM_W-1:0]   sum_q;
    logic signed [SUM_W:0]     rnd;
    logic signed [SUM_W:0]     whole;

    // ------------------------------
    // stage 1 multiply
    // ------------------------------
    always_ff @(posedge clk) begin
        prod0_q  <= $signed({1'b0, color0_i}) * gain0_i;
        prod1_q  <= $signed({1'b0, color1_i}) * gain1_i;
        prod2_q  <= $signed({1'b0, color2_i}) * gain2_i;
        offset_q <= offset_i;
    end

    // ------------------------------
    // stage 2 accumulate
    // ------------------------------
    always_ff @(posedge clk) begin
        sum_q <= SUM_W'(prod0_q) + SUM_W'(prod1_q) + SUM_W'(prod2_q) + SUM_W'(offset_q);
    end

    // round half up, then drop the fraction
    always_comb begin
        rnd   = sum_q + HALF;
        whole = rnd >>> COEFF_FRAC_W;
    end

    // ------------------------------
    // stage 3 clamp
    // ------------------------------
    always_ff @(posedge clk) begin
        if (whole < $signed({1'b0, clip_min_i})) begin
            color_o <= clip_min_i;
        end else if (whole > $signed({1'b0, clip_max_i})) begin
            color_o <= clip_max_i;
        end else begin
            color_o <= whole[DATA_W-1:0];
        end
    end

endmodule

// ==== ccm/ccm_core.sv ====
// ------------------------------
// three channel pipelines with a matching valid pipe
// no back-pressure, a pixel may enter on every cycle
// ------------------------------

`timescale 1ns/1ps

module ccm_core import ccm_pkg::*; #(
    parameter int DATA_W       = 10,
    parameter int COEFF_FRAC_W = 8
) (
    input  logic                      clk,
    input  logic                      s_wb_rst_i,
    input  logic signed [COEFF_W-1:0] mat00_i,
    input  logic signed [COEFF_W-1:0] mat01_i,
    input  logic signed [COEFF_W-1:0] mat02_i,
    input  logic signed [COEFF_W-1:0] mat03_i,
    input  logic signed [COEFF_W-1:0] mat10_i,
    input  logic signed [COEFF_W-1:0] mat11_i,
    input  logic signed [COEFF_W-1:0] mat12_i,
    input  logic signed [COEFF_W-1:0] mat13_i,
    input  logic signed [COEFF_W-1:0] mat20_i,
    input  logic signed [COEFF_W-1:0] mat21_i,
    input  logic signed [COEFF_W-1:0] mat22_i,
    input  logic signed [COEFF_W-1:0] mat23_i,
    input  logic [DATA_W-1:0]         clip_min0_i,
    input  logic [DATA_W-1:0]         clip_max0_i,
    input  logic [DATA_W-1:0]         clip_min1_i,
    input  logic [DATA_W-1:0]         clip_max1_i,
    input  logic [DATA_W-1:0]         clip_min2_i,
    input  logic [DATA_W-1:0]         clip_max2_i,
    input  logic                      s_img_valid_i,
    input  logic [DATA_W-1:0]         s_img_color0_i,
    input  logic [DATA_W-1:0]         s_img_color1_i,
    input  logic [DATA_W-1:0]         s_img_color2_i,
    output logic                      m_img_valid_o,
    output logic [DATA_W-1:0]         m_img_color0_o,
    output logic [DATA_W-1:0]         m_img_color1_o,
    output logic [DATA_W-1:0]         m_img_color2_o
);

    // must track the stage count of ccm_channel
    localparam int LATENCY = 3;

    logic [LATENCY-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LATENCY-2:0], s_img_valid_i};
        end
    end

    assign m_img_valid_o = valid_q[LATENCY-1];

    // ------------------------------
    // one row per output channel
    // ------------------------------
    ccm_channel #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_ch0 (
        .clk        (clk),
        .color0_i   (s_img_color0_i),
        .color1_i   (s_img_color1_i),
        .color2_i   (s_img_color2_i),
        .gain0_i    (mat00_i),
        .gain1_i    (mat01_i),
        .gain2_i    (mat02_i),
        .offset_i   (mat03_i),
        .clip_min_i (clip_min0_i),
        .clip_max_i (clip_max0_i),
        .color_o    (m_img_color0_o)
    );

    ccm_channel #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_ch1 (
        .clk        (clk),
        .color0_i   (s_img_color0_i),
        .color1_i   (s_img_color1_i),
        .color2_i   (s_img_color2_i),
        .gain0_i    (mat10_i),
        .gain1_i    (mat11_i),
        .gain2_i    (mat12_i),
        .offset_i   (mat13_i),
        .clip_min_i (clip_min1_i),
        .clip_max_i (clip_max1_i),
        .color_o    (m_img_color1_o)
    );

    ccm_channel #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_ch2 (
        .clk        (clk),
        .color0_i   (s_img_color0_i),
        .color1_i   (s_img_color1_i),
        .color2_i   (s_img_color2_i),
        .gain0_i    (mat20_i),
        .gain1_i    (mat21_i),
        .gain2_i    (mat22_i),
        .offset_i   (mat23_i),
        .clip_min_i (clip_min2_i),
        .clip_max_i (clip_max2_i),
        .color_o    (m_img_color2_o)
    );

endmodule

// ==== hw/color_matrix_top.sv ====
// ------------------------------
// colour correction matrix, bus and pixels on one clock
// pixel latency is fixed at 3 cycles
// change settings only with no pixel in flight
// ------------------------------

`timescale 1ns/1ps

module color_matrix_top import ccm_pkg::*; #(
    parameter int DATA_W       = 10,
    parameter int COEFF_FRAC_W = 8
) (
    input  logic                clk,
    input  logic                s_wb_rst_i,
    input  logic [WB_ADR_W-1:0] s_wb_adr_i,
    input  logic [WB_DAT_W-1:0] s_wb_dat_i,
    output logic [WB_DAT_W-1:0] s_wb_dat_o,
    input  logic                s_wb_we_i,
    input  logic [WB_SEL_W-1:0] s_wb_sel_i,
    input  logic                s_wb_stb_i,
    output logic                s_wb_ack_o,
    input  logic                s_img_valid_i,
    input  logic [DATA_W-1:0]   s_img_color0_i,
    input  logic [DATA_W-1:0]   s_img_color1_i,
    input  logic [DATA_W-1:0]   s_img_color2_i,
    output logic                m_img_valid_o,
    output logic [DATA_W-1:0]   m_img_color0_o,
    output logic [DATA_W-1:0]   m_img_color1_o,
    output logic [DATA_W-1:0]   m_img_color2_o
);

    // ------------------------------
    // settings from bank to core
    // ------------------------------
    logic signed [COEFF_W-1:0] mat00, mat01, mat02, mat03;
    logic signed [COEFF_W-1:0] mat10, mat11, mat12, mat13;
    logic signed [COEFF_W-1:0] mat20, mat21, mat22, mat23;
    logic [DATA_W-1:0]         clip_min0, clip_max0;
    logic [DATA_W-1:0]         clip_min1, clip_max1;
    logic [DATA_W-1:0]         clip_min2, clip_max2;

    ccm_regs #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_regs (
        .clk         (clk),
        .s_wb_rst_i  (s_wb_rst_i),
        .s_wb_adr_i  (s_wb_adr_i),
        .s_wb_dat_i  (s_wb_dat_i),
        .s_wb_dat_o  (s_wb_dat_o),
        .s_wb_we_i   (s_wb_we_i),
        .s_wb_sel_i  (s_wb_sel_i),
        .s_wb_stb_i  (s_wb_stb_i),
        .s_wb_ack_o  (s_wb_ack_o),
        .mat00_o     (mat00),
        .mat01_o     (mat01),
        .mat02_o     (mat02),
        .mat03_o     (mat03),
        .mat10_o     (mat10),
        .mat11_o     (mat11),
        .mat12_o     (mat12),
        .mat13_o     (mat13),
        .mat20_o     (mat20),
        .mat21_o     (mat21),
        .mat22_o     (mat22),
        .mat23_o     (mat23),
        .clip_min0_o (clip_min0),
        .clip_max0_o (clip_max0),
        .clip_min1_o (clip_min1),
        .clip_max1_o (clip_max1),
        .clip_min2_o (clip_min2),
        .clip_max2_o (clip_max2)
    );

    ccm_core #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_core (
        .clk            (clk),
        .s_wb_rst_i     (s_wb_rst_i),
        .mat00_i        (mat00),
        .mat01_i        (mat01),
        .mat02_i        (mat02),
        .mat03_i        (mat03),
        .mat10_i        (mat10),
        .mat11_i        (mat11),
        .mat12_i        (mat12),
        .mat13_i        (mat13),
        .mat20_i        (mat20),
        .mat21_i        (mat21),
        .mat22_i        (mat22),
        .mat23_i        (mat23),
        .clip_min0_i    (clip_min0),
        .clip_max0_i    (clip_max0),
        .clip_min1_i    (clip_min1),
        .clip_max1_i    (clip_max1),
        .clip_min2_i    (clip_min2),
        .clip_max2_i    (clip_max2),
        .s_img_valid_i  (s_img_valid_i),
        .s_img_color0_i (s_img_color0_i),
        .s_img_color1_i (s_img_color1_i),
        .s_img_color2_i (s_img_color2_i),
        .m_img_valid_o  (m_img_valid_o),
        .m_img_color0_o (m_img_color0_o),
        .m_img_color1_o (m_img_color1_o),
        .m_img_color2_o (m_img_color2_o)
    );

endmodule

// ==== testbench/tb_color_matrix_sva.sv ====
// ------------------------------
// checks bound into color_matrix_top
// clip check assumes settings hold still while pixels flow
// ------------------------------

`timescale 1ns/1ps

module tb_color_matrix_sva #(
    parameter int DATA_W = 10
) (
    input logic              clk,
    input logic              s_wb_rst_i,
    input logic              s_wb_stb_i,
    input logic              s_wb_ack_o,
    input logic              s_img_valid_i,
    input logic              m_img_valid_o,
    input logic [DATA_W-1:0] m_img_color0_o, m_img_color1_o, m_img_color2_o,
    input logic [DATA_W-1:0] clip_min0, clip_max0,
    input logic [DATA_W-1:0] clip_min1, clip_max1,
    input logic [DATA_W-1:0] clip_min2, clip_max2
);

    // count of failed assertions
    int fail_count = 0;

    a_ack_follows_stb: assert property (@(posedge clk) s_wb_ack_o == s_wb_stb_i)
        else begin
            fail_count++;
            $error("bus acknowledge differs from strobe");
        end

    // three register stages from input to output
    a_valid_latency: assert property (@(posedge clk) disable iff (s_wb_rst_i)
        m_img_valid_o == $past(s_img_valid_i, 3))
        else begin
            fail_count++;
            $error("output valid is not the input valid delayed by three cycles");
        end

    // ------------------------------
    // outputs inside the clip window
    // ------------------------------
    a_clip0: assert property (@(posedge clk) disable iff (s_wb_rst_i)
        m_img_valid_o |-> (m_img_color0_o >= clip_min0 && m_img_color0_o <= clip_max0))
        else begin
            fail_count++;
            $error("channel 0 output outside its clip limits");
        end

    a_clip1: assert property (@(posedge clk) disable iff (s_wb_rst_i)
        m_img_valid_o |-> (m_img_color1_o >= clip_min1 && m_img_color1_o <= clip_max1))
        else begin
            fail_count++;
            $error("channel 1 output outside its clip limits");
        end

    a_clip2: assert property (@(posedge clk) disable iff (s_wb_rst_i)
        m_img_valid_o |-> (m_img_color2_o >= clip_min2 && m_img_color2_o <= clip_max2))
        else begin
            fail_count++;
            $error("channel 2 output outside its clip limits");
        end

endmodule

bind color_matrix_top tb_color_matrix_sva #(.DATA_W(DATA_W)) u_sva (.*);

// ==== testbench/tb_color_matrix.sv ====
// ------------------------------
// testbench for the colour matrix, fixed seed random stimulus
// expected pixels come from a model of the matrix rule
// ------------------------------

`timescale 1ns/1ps

module tb_color_matrix import ccm_pkg::*; ();

    localparam int DATA_W        = 10;
    localparam int COEFF_FRAC_W  = 8;
    localparam int N_REGS        = 18;
    localparam int N_PIX_DEF     = 40;
    localparam int N_WRITES      = 60;
    localparam int N_UNMAPPED    = 8;
    localparam int N_MAT_ROUNDS  = 3;
    localparam int N_CLIP_ROUNDS = 4;
    localparam int N_BURST       = 100;
    localparam int MAX_GAP       = 3;
    // bus accesses take up to 3 cycles, pixels up to MAX_GAP + 1
    localparam int N_BUS = N_REGS + N_WRITES * 2 + N_UNMAPPED * (2 + N_REGS)
                           + (N_MAT_ROUNDS + N_CLIP_ROUNDS) * N_REGS;
    localparam int N_PIX = N_PIX_DEF + (N_MAT_ROUNDS + N_CLIP_ROUNDS) * N_BURST;
    localparam int TEST_CYCLES = 16 + N_BUS * 3 + N_PIX * (MAX_GAP + 1) + 8 * 10;

    logic                clk;
    logic                s_wb_rst_i;
    logic [WB_ADR_W-1:0] s_wb_adr_i;
    logic [WB_DAT_W-1:0] s_wb_dat_i;
    logic [WB_DAT_W-1:0] s_wb_dat_o;
    logic                s_wb_we_i;
    logic [WB_SEL_W-1:0] s_wb_sel_i;
    logic                s_wb_stb_i;
    logic                s_wb_ack_o;
    logic                s_img_valid_i;
    logic [DATA_W-1:0]   s_img_color0_i;
    logic [DATA_W-1:0]   s_img_color1_i;
    logic [DATA_W-1:0]   s_img_color2_i;
    logic                m_img_valid_o;
    logic [DATA_W-1:0]   m_img_color0_o;
    logic [DATA_W-1:0]   m_img_color1_o;
    logic [DATA_W-1:0]   m_img_color2_o;

    integer seed = 32'h2290;
    int     errors;
    int     err_mark;
    int     sva_mark;
    int     tests_run;
    int     tests_failed;
    int     pix_in;
    int     pix_out;

    // expected readback of every register, in address order
    logic [WB_DAT_W-1:0] shadow [N_REGS];
    logic [3*DATA_W-1:0] exp_q [$];

    color_matrix_top #(.DATA_W(DATA_W), .COEFF_FRAC_W(COEFF_FRAC_W)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [WB_ADR_W-1:0] reg_addr(input int idx);
        if (idx < 12) begin
            return WB_ADR_W'(MAT00) + WB_ADR_W'(idx);
        end
        return WB_ADR_W'(CLIP_MIN0) + WB_ADR_W'(idx - 12);
    endfunction

    // readback after a byte-masked write, cut to the field width
    function automatic logic [WB_DAT_W-1:0] merged(
        input int                  idx,
        input logic [WB_DAT_W-1:0] dat,
        input logic [WB_SEL_W-1:0] sel
    );
        logic [WB_DAT_W-1:0] v;
        v = shadow[idx];
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                v[8*b +: 8] = dat[8*b +: 8];
            end
        end
        if (idx < 12) begin
            return {{(WB_DAT_W-COEFF_W){v[COEFF_W-1]}}, v[COEFF_W-1:0]};
        end
        return {{(WB_DAT_W-DATA_W){1'b0}}, v[DATA_W-1:0]};
    endfunction

    function automatic logic [DATA_W-1:0] model_channel(
        input int                row,
        input logic [DATA_W-1:0] c0,
        input logic [DATA_W-1:0] c1,
        input logic [DATA_W-1:0] c2
    );
        longint acc;
        longint lo;
        longint hi;
        acc = longint'($signed(shadow[4*row])) * longint'(c0)
            + longint'($signed(shadow[4*row+1])) * longint'(c1)
            + longint'($signed(shadow[4*row+2])) * longint'(c2)
            + longint'($signed(shadow[4*row+3]));
        // add a half, then floor
        acc = (acc + (64'sd1 <<< (COEFF_FRAC_W - 1))) >>> COEFF_FRAC_W;
        lo  = longint'(shadow[12 + 2*row]);
        hi  = longint'(shadow[13 + 2*row]);
        if (acc < lo) begin
            return DATA_W'(lo);
        end
        if (acc > hi) begin
            return DATA_W'(hi);
        end
        return acc[DATA_W-1:0];
    endfunction

    task automatic load_defaults();
        for (int i = 0; i < N_REGS; i++) begin
            shadow[i] = '0;
        end
        shadow[0]  = 1 << COEFF_FRAC_W;
        shadow[5]  = 1 << COEFF_FRAC_W;
        shadow[10] = 1 << COEFF_FRAC_W;
        shadow[13] = (1 << DATA_W) - 1;
        shadow[15] = (1 << DATA_W) - 1;
        shadow[17] = (1 << DATA_W) - 1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] got);
        errors++;
        $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expv, got);
    endtask

    // ------------------------------
    // bus access
    // ------------------------------
    task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat,
                             input logic [WB_SEL_W-1:0] sel);
        @(posedge clk);
        s_wb_stb_i <= 1'b1;
        s_wb_we_i  <= 1'b1;
        s_wb_adr_i <= adr;
        s_wb_dat_i <= dat;
        s_wb_sel_i <= sel;
        @(posedge clk);
        s_wb_stb_i <= 1'b0;
        s_wb_we_i  <= 1'b0;
    endtask

    task automatic bus_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        @(posedge clk);
        s_wb_stb_i <= 1'b1;
        s_wb_we_i  <= 1'b0;
        s_wb_adr_i <= adr;
        @(negedge clk);
        dat = s_wb_dat_o;
        if (s_wb_ack_o !== 1'b1) begin
            report_mismatch("s_wb_ack_o", 1, s_wb_ack_o);
        end
        @(posedge clk);
        s_wb_stb_i <= 1'b0;
    endtask

    task automatic write_reg(input int idx, input logic [WB_DAT_W-1:0] dat,
                             input logic [WB_SEL_W-1:0] sel);
        bus_write(reg_addr(idx), dat, sel);
        shadow[idx] = merged(idx, dat, sel);
    endtask

    task automatic check_all_regs();
        logic [WB_DAT_W-1:0] rd;
        for (int i = 0; i < N_REGS; i++) begin
            bus_read(reg_addr(i), rd);
            if (rd !== shadow[i]) begin
                report_mismatch("s_wb_dat_o", shadow[i], rd);
            end
        end
    endtask

    // gains within +-4.0, offsets wide or negative, clip window full or narrow
    // coarse settings keep half steps only, so sums land on exact halves
    task automatic program_settings(input bit narrow, input bit coarse);
        int v;
        int lo;
        for (int i = 0; i < 12; i++) begin
            if (i % 4 != 3) begin
                v = $random(seed) % ((4 << COEFF_FRAC_W) + 1);
            end else if (narrow) begin
                v = $random(seed) % (512 << COEFF_FRAC_W);
                v = (v > 0) ? -v : v;
            end else begin
                v = $random(seed) % (64 << COEFF_FRAC_W);
            end
            if (coarse) begin
                v = v & ~((1 << (COEFF_FRAC_W - 1)) - 1);
            end
            write_reg(i, WB_DAT_W'(v), '1);
        end
        for (int c = 0; c < 3; c++) begin
            lo = narrow ? $unsigned($random(seed)) % 900 : 0;
            write_reg(12 + 2*c, WB_DAT_W'(lo), '1);
            v = narrow ? lo + 8 + $unsigned($random(seed)) % 100 : (1 << DATA_W) - 1;
            write_reg(13 + 2*c, WB_DAT_W'(v), '1);
        end
        repeat (4) @(posedge clk);
    endtask

    // ------------------------------
    // pixel stream
    // ------------------------------
    task automatic send_burst(input int n);
        logic [DATA_W-1:0] c0;
        logic [DATA_W-1:0] c1;
        logic [DATA_W-1:0] c2;
        int                gap;
        for (int p = 0; p < n; p++) begin
            c0 = DATA_W'($random(seed));
            c1 = DATA_W'($random(seed));
            c2 = DATA_W'($random(seed));
            exp_q.push_back({model_channel(2, c0, c1, c2), model_channel(1, c0, c1, c2),
                             model_channel(0, c0, c1, c2)});
            pix_in++;
            @(posedge clk);
            s_img_valid_i  <= 1'b1;
            s_img_color0_i <= c0;
            s_img_color1_i <= c1;
            s_img_color2_i <= c2;
            // two thirds of the pixels follow back to back
            gap = $unsigned($random(seed)) % (2 * MAX_GAP);
            gap = (gap >= MAX_GAP) ? 0 : gap;
            repeat (gap) begin
                @(posedge clk);
                s_img_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        s_img_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(negedge clk) begin
        logic [3*DATA_W-1:0] e;
        if (s_wb_rst_i === 1'b1 && m_img_valid_o === 1'b1) begin
            errors++;
            $display("output valid raised during reset at %0t ns", $time);
        end else if (m_img_valid_o === 1'b1) begin
            pix_out++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("output pixel at %0t ns without a pending input pixel", $time);
            end else begin
                e = exp_q.pop_front();
                if (m_img_color0_o !== e[DATA_W-1:0]) begin
                    report_mismatch("m_img_color0_o", e[DATA_W-1:0], m_img_color0_o);
                end
                if (m_img_color1_o !== e[2*DATA_W-1:DATA_W]) begin
                    report_mismatch("m_img_color1_o", e[2*DATA_W-1:DATA_W], m_img_color1_o);
                end
                if (m_img_color2_o !== e[3*DATA_W-1:2*DATA_W]) begin
                    report_mismatch("m_img_color2_o", e[3*DATA_W-1:2*DATA_W], m_img_color2_o);
                end
            end
        end
    end

    task automatic finish_test(input string name);
        // bound assertion failures since the last test
        errors   = errors + u_dut.u_sva.fail_count - sva_mark;
        sva_mark = u_dut.u_sva.fail_count;
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        #(TEST_CYCLES * 20 * 2);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [WB_DAT_W-1:0] rd;
        logic [WB_DAT_W-1:0] wd;
        logic [WB_SEL_W-1:0] sel;
        logic [WB_ADR_W-1:0] adr;
        int                  idx;
        errors         = 0;
        err_mark       = 0;
        sva_mark       = 0;
        tests_run      = 0;
        tests_failed   = 0;
        pix_in         = 0;
        pix_out        = 0;
        s_wb_rst_i     <= 1'b1;
        s_wb_adr_i     <= '0;
        s_wb_dat_i     <= '0;
        s_wb_we_i      <= 1'b0;
        s_wb_sel_i     <= '0;
        s_wb_stb_i     <= 1'b0;
        s_img_valid_i  <= 1'b0;
        s_img_color0_i <= '0;
        s_img_color1_i <= '0;
        s_img_color2_i <= '0;
        load_defaults();
        repeat (16) @(posedge clk);
        s_wb_rst_i <= 1'b0;

        check_all_regs();
        send_burst(N_PIX_DEF);
        finish_test("reset defaults");

        for (int i = 0; i < N_WRITES; i++) begin
            idx = $unsigned($random(seed)) % N_REGS;
            wd  = $random(seed);
            sel = WB_SEL_W'($random(seed));
            write_reg(idx, wd, sel);
            bus_read(reg_addr(idx), rd);
            if (rd !== shadow[idx]) begin
                report_mismatch("s_wb_dat_o", shadow[idx], rd);
            end
        end
        for (int i = 0; i < N_UNMAPPED; i++) begin
            adr = WB_ADR_W'($random(seed));
            while (adr <= MAT23 || (adr >= CLIP_MIN0 && adr <= CLIP_MAX2)) begin
                adr = WB_ADR_W'($random(seed));
            end
            bus_write(adr, $random(seed), '1);
            bus_read(adr, rd);
            if (rd !== '0) begin
                report_mismatch("s_wb_dat_o", 0, rd);
            end
            check_all_regs();
        end
        finish_test("byte select writes");

        for (int r = 0; r < N_MAT_ROUNDS; r++) begin
            program_settings(1'b0, r == 0);
            send_burst(N_BURST);
        end
        finish_test("random matrix");

        for (int r = 0; r < N_CLIP_ROUNDS; r++) begin
            program_settings(1'b1, 1'b0);
            send_burst(N_BURST);
        end
        finish_test("clipping");

        if (pix_out != pix_in) begin
            report_mismatch("m_img_valid_o count", pix_in, pix_out);
        end
        finish_test("valid count");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
common/ccm_pkg.sv
ccm/ccm_regs.sv
ccm/ccm_channel.sv
ccm/ccm_core.sv
hw/color_matrix_top.sv
testbench/tb_color_matrix_sva.sv
testbench/tb_color_matrix.sv
